/* Bender.yml */
package:
  name: conv_tile

sources:
  - tile_pkg.sv
  - layer_cmd_decode.sv
  - tile_walker.sv
  - tile_sequencer.sv
  - tile_desc_gen.sv
  - conv_tile_top.sv
  - target: test
    files:
      - tb_conv_tile.sv

/* all.f */
tile_pkg.sv
layer_cmd_decode.sv
tile_walker.sv
tile_sequencer.sv
tile_desc_gen.sv
conv_tile_top.sv
tb_conv_tile.sv

/* conv_tile_top.sv */
//********************
// conv tile control top
// command decode, tile sequencing and descriptor output
//********************

`timescale 1ns/1ns

module conv_tile_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  tile_pkg::cmd_t       cmd,
    output logic                 busy,
    output tile_pkg::tile_desc_t desc,
    output logic                 desc_valid,
    output logic                 layer_done
);

    tile_pkg::layer_cfg_t cfg;
    tile_pkg::tile_cord_t cord;
    logic                 start;
    logic                 issue;
    logic                 is_last;

    layer_cmd_decode decode_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .cfg       (cfg),
        .start     (start)
    );

    tile_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .issue      (issue),
        .tile_done  (),
        .cord       (cord),
        .is_last    (is_last),
        .busy       (busy),
        .layer_done (layer_done)
    );

    tile_desc_gen desc_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .cord       (cord),
        .is_last    (is_last),
        .cfg        (cfg),
        .desc       (desc),
        .desc_valid (desc_valid)
    );

endmodule

/* conv_tile_trace.txt */
# c <op> <data>: host command in hex, op 0 base_in, 1 base_w, 2 base_out, 3 run
# w <k>: wait for k descriptors in total; e <k> <in> <w> <out> <first_m> <last>: descriptor k
c 0 00001000
c 1 00020000
c 2 00400000
c 3 00000000
e 1 00001000 00020000 00400000 1 0
e 2 00001006 00020000 00400006 1 0
e 3 0000100c 00020000 0040000c 1 0
e 4 00001060 00020000 00400054 1 0
e 5 00001066 00020000 0040005a 1 0
w 5
c 0 0000beef
e 6 0000106c 00020000 00400060 1 0
e 9 000010cc 00020000 004000b4 1 0
e 10 00002000 00020090 00400000 0 0
e 19 00001000 00021200 00400c40 1 0
e 36 000020cc 00021290 00400cf4 0 1
w 36
c 0 00008000
c 1 00030000
c 2 00500000
c 3 00000000
e 37 00008000 00030000 00500000 1 0
e 38 00008006 00030000 00500006 1 0
e 55 00008000 00031200 00500c40 1 0
e 72 000090cc 00031290 00500cf4 0 1
w 72

/* layer_cmd_decode.sv */
//********************
// layer command decoder
// loads the base address registers and raises the run pulse
//********************

`timescale 1ns/1ns

module layer_cmd_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  tile_pkg::cmd_t       cmd,
    input  logic                 busy,
    output tile_pkg::layer_cfg_t cfg,
    output logic                 start
);

    logic cmd_take;

    // commands arriving during a layer are dropped.
    assign cmd_take = cmd_valid && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0; // one cycle only.
            if (cmd_take) begin
                case (cmd.op)
                    tile_pkg::OP_SET_IN: begin
                        cfg.base_in <= cmd.data;
                    end
                    tile_pkg::OP_SET_W: begin
                        cfg.base_w <= cmd.data;
                    end
                    tile_pkg::OP_SET_OUT: begin
                        cfg.base_out <= cmd.data;
                    end
                    tile_pkg::OP_RUN: begin
                        start <= 1'b1; // data field unused.
                    end
                    default: begin
                        start <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* tb_conv_tile.sv */
//********************
// conv tile testbench
// replays the trace file and checks descriptors and layer status
//********************

`timescale 1ns/1ns

module tb_conv_tile;

    localparam int LIMIT = 2 * tile_pkg::TILES_PER_LAYER * (tile_pkg::TILE_CYCLES + 1) + 200;

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    tile_pkg::cmd_t       cmd;
    logic                 busy;
    tile_pkg::tile_desc_t desc;
    logic                 desc_valid;
    logic                 layer_done;

    string                step_kind[$];
    logic [31:0]          step_a[$];
    logic [31:0]          step_b[$];
    tile_pkg::tile_desc_t spot_desc [0:255]; // expected descriptors by arrival number.
    bit                   spot_have [0:255];
    logic [31:0]          base_in;
    logic [31:0]          base_w;
    logic [31:0]          base_out;
    logic                 layer_active;
    logic                 last_seen;
    logic                 after_done;
    int                   desc_count;
    int                   total_descs;
    int                   done_gap;
    int                   cycles;

    conv_tile_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .desc       (desc),
        .desc_valid (desc_valid),
        .layer_done (layer_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // walker order is col, then row, then m, then n.
    function automatic tile_pkg::tile_desc_t expected_desc(input int idx);
        tile_pkg::tile_desc_t d;
        int n_col;
        int n_row;
        int n_m;
        int col;
        int row;
        int m;
        int n;
        n_col = (tile_pkg::C_OUT + tile_pkg::COL_STEP - 1) / tile_pkg::COL_STEP;
        n_row = (tile_pkg::R_OUT + tile_pkg::ROW_STEP - 1) / tile_pkg::ROW_STEP;
        n_m   = (tile_pkg::M_IN + tile_pkg::TM - 1) / tile_pkg::TM;
        col   = (idx % n_col) * tile_pkg::COL_STEP;
        row   = ((idx / n_col) % n_row) * tile_pkg::ROW_STEP;
        m     = ((idx / (n_col * n_row)) % n_m) * tile_pkg::TM;
        n     = (idx / (n_col * n_row * n_m)) * tile_pkg::TN;
        d.in_addr  = base_in + (m * tile_pkg::R_IN + row) * tile_pkg::C_IN + col;
        d.w_addr   = base_w + (n * tile_pkg::M_IN + m) * tile_pkg::K * tile_pkg::K;
        d.out_addr = base_out + (n * tile_pkg::R_OUT + row) * tile_pkg::C_OUT + col;
        d.first_m  = (m == 0);
        d.last     = (idx == tile_pkg::TILES_PER_LAYER - 1);
        return d;
    endfunction

    task automatic load_trace();
        int          fd;
        int          r;
        int          k;
        string       kind;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] f;
        logic [31:0] l;
        fd = $fopen("conv_tile_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file conv_tile_trace.txt");
            $display("sim failed");
            $fatal(1, "no trace");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "c" || kind == "w") begin
                    if (kind == "c") begin
                        r = $fscanf(fd, "%h %h", a, b);
                    end else begin
                        r = $fscanf(fd, "%d", a);
                        b = '0;
                        total_descs = a;
                    end
                    step_kind.push_back(kind);
                    step_a.push_back(a);
                    step_b.push_back(b);
                end else if (kind == "e") begin
                    r = $fscanf(fd, "%d %h %h %h %h %h", k, a, b, c, f, l);
                    spot_desc[k] = {a, b, c, f[0], l[0]};
                    spot_have[k] = 1'b1;
                end else begin
                    r = $fgets(rest, fd); // comment line.
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_cmd(input logic [31:0] op, input logic [31:0] data);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd.op    = tile_pkg::cmd_op_e'(op[1:0]);
        cmd.data  = data;
        if (!layer_active) begin // a running layer drops every command.
            case (op[1:0])
                2'd0: base_in = data;
                2'd1: base_w = data;
                2'd2: base_out = data;
                default: layer_active = 1'b1;
            endcase
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_descs(input int k);
        while (desc_count < k) begin
            @(posedge clk);
        end
        // after the last tile the layer has to wind down first.
        if (last_seen) begin
            while (busy || layer_active) begin
                @(posedge clk);
            end
        end
    endtask

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: descriptors did not finish");
            $display("sim failed");
            $fatal(1, "timeout");
        end else if (!rst) begin
            if (done_gap >= 0) begin
                done_gap = done_gap + 1;
            end
            check_value("layer_done", layer_done, done_gap == tile_pkg::TILE_CYCLES - 1);
            if (after_done) begin
                check_value("busy", busy, 1'b0); // busy drops right after layer_done.
            end
            after_done = layer_done;
            if (layer_done) begin
                check_value("busy", busy, 1'b1);
                done_gap     = -1;
                layer_active = 1'b0;
            end
            if (desc_valid) begin
                check_value("desc_valid", 1'b1, layer_active);
                check_value("busy", busy, 1'b1);
                check_value("desc", desc, expected_desc(desc_count % tile_pkg::TILES_PER_LAYER));
                desc_count = desc_count + 1;
                if (spot_have[desc_count]) begin
                    check_value("desc", desc, spot_desc[desc_count]);
                end
                last_seen = desc.last;
                if (desc.last) begin
                    done_gap = 0;
                end
            end
        end
    end

    initial begin
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        base_in      = '0;
        base_w       = '0;
        base_out     = '0;
        layer_active = 1'b0;
        last_seen    = 1'b0;
        after_done   = 1'b0;
        desc_count   = 0;
        total_descs  = 0;
        done_gap     = -1;
        cycles       = 0;
        load_trace();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("desc_valid", desc_valid, 1'b0);
        check_value("layer_done", layer_done, 1'b0);
        foreach (step_kind[i]) begin
            if (step_kind[i] == "c") begin
                send_cmd(step_a[i], step_b[i]);
            end else begin
                wait_descs(step_a[i]);
            end
        end
        repeat (4 * tile_pkg::TILE_CYCLES) @(posedge clk); // no stray descriptors.
        check_value("desc_count", desc_count, total_descs);
        $display("sim passed");
        $finish;
    end

endmodule

/* tile_desc_gen.sv */
//********************
// descriptor generator
// maps tile coordinates to word addresses for the dma
//********************

`timescale 1ns/1ns

module tile_desc_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  tile_pkg::tile_cord_t cord,
    input  logic                 is_last,
    input  tile_pkg::layer_cfg_t cfg,
    output tile_pkg::tile_desc_t desc,
    output logic                 desc_valid
);

    localparam int PAD = tile_pkg::AW - tile_pkg::CW;

    logic [tile_pkg::AW-1:0] n_ext;
    logic [tile_pkg::AW-1:0] m_ext;
    logic [tile_pkg::AW-1:0] row_ext;
    logic [tile_pkg::AW-1:0] col_ext;
    tile_pkg::tile_desc_t    desc_next;

    assign n_ext   = {{PAD{1'b0}}, cord.n};
    assign m_ext   = {{PAD{1'b0}}, cord.m};
    assign row_ext = {{PAD{1'b0}}, cord.row};
    assign col_ext = {{PAD{1'b0}}, cord.col};

    // input map is stored m, row, col.
    assign desc_next.in_addr  = cfg.base_in +
                                (m_ext * tile_pkg::R_IN + row_ext) * tile_pkg::C_IN + col_ext;
    // one k by k kernel per (n, m) pair.
    assign desc_next.w_addr   = cfg.base_w +
                                (n_ext * tile_pkg::M_IN + m_ext) * tile_pkg::K * tile_pkg::K;
    assign desc_next.out_addr = cfg.base_out +
                                (n_ext * tile_pkg::R_OUT + row_ext) * tile_pkg::C_OUT + col_ext;
    assign desc_next.first_m  = (cord.m == '0);
    assign desc_next.last     = is_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            desc <= desc_next;
        end
    end

endmodule

/* tile_pkg.sv */
//********************
// tile control package
// layer shape, opcodes, states and the shared bus structs
//********************

package tile_pkg;

    // layer shape.
    localparam int N_OUT = 32;
    localparam int M_IN  = 32;
    localparam int R_IN  = 16;
    localparam int C_IN  = 16;
    localparam int TN    = 16;
    localparam int TM    = 16;
    localparam int TR    = 8;
    localparam int TC    = 8;
    localparam int K     = 3;
    localparam int S     = 1;

    // tiles overlap by K - S rows and columns.
    localparam int ROW_STEP = ((TR + S - K) / S) * S;
    localparam int COL_STEP = ((TC + S - K) / S) * S;
    localparam int R_OUT    = ((R_IN + S - K) / S) * S;
    localparam int C_OUT    = ((C_IN + S - K) / S) * S;

    localparam int TILE_CYCLES = 8; // stands in for the mac array.
    localparam int TILES_PER_LAYER = ((C_OUT + COL_STEP - 1) / COL_STEP) *
                                     ((R_OUT + ROW_STEP - 1) / ROW_STEP) *
                                     ((M_IN + TM - 1) / TM) *
                                     ((N_OUT + TN - 1) / TN);

    localparam int AW = 32; // word address width.
    localparam int CW = 8;  // tile coordinate width.

    typedef enum logic [1:0] {
        OP_SET_IN,
        OP_SET_W,
        OP_SET_OUT,
        OP_RUN
    } cmd_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_COMPUTE
    } seq_state_e;

    typedef struct packed {
        cmd_op_e         op;
        logic [AW-1:0]   data;
    } cmd_t;

    typedef struct packed {
        logic [AW-1:0]   base_in;
        logic [AW-1:0]   base_w;
        logic [AW-1:0]   base_out;
    } layer_cfg_t;

    typedef struct packed {
        logic [CW-1:0]   n;
        logic [CW-1:0]   m;
        logic [CW-1:0]   row;
        logic [CW-1:0]   col;
    } tile_cord_t;

    typedef struct packed {
        logic [AW-1:0]   in_addr;
        logic [AW-1:0]   w_addr;
        logic [AW-1:0]   out_addr;
        logic            first_m; // clear the accumulator.
        logic            last;    // final tile of the layer.
    } tile_desc_t;

endpackage

/* tile_sequencer.sv */
//********************
// tile sequencer
// issues one tile, waits the compute time, repeats to layer end
//********************

`timescale 1ns/1ns

module tile_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 issue,
    output logic                 tile_done,
    output tile_pkg::tile_cord_t cord,
    output logic                 is_last,
    output logic                 busy,
    output logic                 layer_done
);

    tile_pkg::seq_state_e state;
    logic [$clog2(tile_pkg::TILE_CYCLES)-1:0] cyc_cnt;

    tile_walker walker_i (
        .clk       (clk),
        .rst       (rst),
        .tile_done (tile_done),
        .cord      (cord),
        .is_last   (is_last)
    );

    assign issue      = (state == tile_pkg::ST_ISSUE);
    assign tile_done  = (state == tile_pkg::ST_COMPUTE) &&
                        (cyc_cnt == tile_pkg::TILE_CYCLES - 1);
    assign layer_done = tile_done && is_last; // is_last still shows the finished tile.
    assign busy       = (state != tile_pkg::ST_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= tile_pkg::ST_IDLE;
            cyc_cnt <= '0;
        end else begin
            case (state)
                tile_pkg::ST_IDLE: begin
                    if (start) begin
                        state <= tile_pkg::ST_ISSUE;
                    end
                end
                tile_pkg::ST_ISSUE: begin
                    cyc_cnt <= '0;
                    state   <= tile_pkg::ST_COMPUTE;
                end
                tile_pkg::ST_COMPUTE: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (layer_done) begin
                        state <= tile_pkg::ST_IDLE;
                    end else if (tile_done) begin
                        state <= tile_pkg::ST_ISSUE;
                    end
                end
                default: begin
                    state <= tile_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* tile_walker.sv */
//********************
// tile walker
// steps col, row, m and n tile bases on every finished tile
//********************

`timescale 1ns/1ns

module tile_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tile_done,
    output tile_pkg::tile_cord_t cord,
    output logic                 is_last
);

    logic [tile_pkg::CW-1:0] col_next;
    logic [tile_pkg::CW-1:0] row_next;
    logic [tile_pkg::CW-1:0] m_next;
    logic [tile_pkg::CW-1:0] n_next;
    logic                    last_col;
    logic                    last_row;
    logic                    last_m;
    logic                    last_n;

    assign col_next = cord.col + tile_pkg::COL_STEP[tile_pkg::CW-1:0];
    assign row_next = cord.row + tile_pkg::ROW_STEP[tile_pkg::CW-1:0];
    assign m_next   = cord.m + tile_pkg::TM[tile_pkg::CW-1:0];
    assign n_next   = cord.n + tile_pkg::TN[tile_pkg::CW-1:0];

    // a counter is on its last tile once one more step reaches the limit.
    assign last_col = (cord.col + tile_pkg::COL_STEP) >= tile_pkg::C_OUT;
    assign last_row = (cord.row + tile_pkg::ROW_STEP) >= tile_pkg::R_OUT;
    assign last_m   = (cord.m + tile_pkg::TM) >= tile_pkg::M_IN;
    assign last_n   = (cord.n + tile_pkg::TN) >= tile_pkg::N_OUT;

    assign is_last = last_col && last_row && last_m && last_n;

    // innermost loop is col, outermost is n.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cord <= '0;
        end else if (tile_done) begin
            cord.col <= last_col ? '0 : col_next;
            if (last_col) begin
                cord.row <= last_row ? '0 : row_next;
                if (last_row) begin
                    cord.m <= last_m ? '0 : m_next;
                    if (last_m) begin
                        cord.n <= last_n ? '0 : n_next; // wraps after the final tile.
                    end
                end
            end
        end
    end

endmodule
